//--- design/uart_pkg.sv
////////////////////
// uart package
// frame format, FIFO depths and credit widths shared by
// the UART transceiver blocks
////////////////////

`default_nettype none

package uart_pkg;

  ////////////////////
  // frame format
  ////////////////////

  // data bits per frame
  localparam int unsigned DW = 8;
  // baud counter width, sizes cfg_bdr and cfg_smp
  localparam int unsigned CW = 16;
  // start + data + stop, in bit times
  localparam int unsigned SL = 1 + DW + 1;
  // bit counter width, counts 0 to SL-1
  localparam int unsigned BIT_W = $clog2(SL);

  ////////////////////
  // buffering and credits
  ////////////////////

  // tx FIFO depth, also the host credits after reset
  localparam int unsigned TX_DEPTH = 4;
  localparam int unsigned TX_AW = $clog2(TX_DEPTH);
  // rx FIFO depth
  localparam int unsigned RX_DEPTH = 4;
  localparam int unsigned RX_AW = $clog2(RX_DEPTH);
  // host rx credit counter, holds the larger depth
  localparam int unsigned CRD_W = 3;

  // one data byte on every link
  typedef logic [DW-1:0] byte_t;

endpackage : uart_pkg

`default_nettype wire

//--- design/uart_des.sv
////////////////////
// uart deserializer
// finds the start edge, samples each bit at cfg_smp and
// reports the byte with a stop-bit check
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_des import uart_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  // bit timing
  input  logic [CW-1:0] cfg_bdr,
  input  logic [CW-1:0] cfg_smp,
  // serial line
  input  logic          rxd,
  // received byte, no flow control
  output logic          des_vld,
  output byte_t         des_dat,
  output logic          des_err
);

  // start edge
  logic             rxd_dly;
  logic             rxd_edg;
  // baud timing
  logic [CW-1:0]    bdr_cnt;
  logic             bdr_end;
  logic             bdr_smp;
  // bit sequencing
  logic [BIT_W-1:0] bit_cnt;
  logic             bit_end;
  logic             run;
  // data bits, lsb first so they enter at the top
  byte_t            shf;

  ////////////////////
  // start detection
  ////////////////////

  // line idles high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) rxd_dly <= 1'b1;
    else     rxd_dly <= rxd;
  end

  // high to low while idle starts a frame
  assign rxd_edg = rxd_dly & ~rxd;

  ////////////////////
  // baud and bit counters
  ////////////////////

  assign bdr_end = bdr_cnt == cfg_bdr;
  assign bdr_smp = run & (bdr_cnt == cfg_smp);
  assign bit_end = bit_cnt == BIT_W'(SL - 1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
      bit_cnt <= '0;
      run     <= 1'b0;
      des_vld <= 1'b0;
    end else begin
      // valid one cycle after the stop sample
      des_vld <= bdr_smp & bit_end;
      if (!run || bdr_end) bdr_cnt <= '0;
      else                 bdr_cnt <= bdr_cnt + 1'b1;
      if (!run) begin
        if (rxd_edg) begin
          run     <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (bit_end) begin
        // stop sampled, line handed back to edge detect
        if (bdr_smp) begin
          run     <= 1'b0;
          bit_cnt <= '0;
        end
      end else if (bdr_end) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // sampling
  ////////////////////

  // start sample falls out the bottom after eight data samples
  always_ff @(posedge clk) begin
    if (bdr_smp && !bit_end) shf <= {rxd, shf[DW-1:1]};
  end

  // byte and stop check held until the next frame ends
  always_ff @(posedge clk) begin
    if (bdr_smp && bit_end) begin
      des_dat <= shf;
      des_err <= ~rxd;
    end
  end

endmodule : uart_des

`default_nettype wire

//--- design/uart_ser.sv
////////////////////
// uart serializer
// frames one byte onto txd and returns its credit
// once the stop bit has ended
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_ser import uart_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  // bit timing
  input  logic [CW-1:0] cfg_bdr,
  // byte from the tx FIFO, one credit deep
  input  logic          ser_vld,
  input  byte_t         ser_dat,
  // serial line and credit return
  output logic          txd,
  output logic          ser_crd
);

  logic [CW-1:0]    bdr_cnt;
  logic             bdr_end;
  logic [BIT_W-1:0] bit_cnt;
  logic             bit_end;
  logic             run;
  // data bits then stop, start goes straight to txd
  logic [DW:0]      shf;

  assign bdr_end = bdr_cnt == cfg_bdr;
  assign bit_end = bit_cnt == BIT_W'(SL - 1);

  ////////////////////
  // framing control
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
      bit_cnt <= '0;
      run     <= 1'b0;
      txd     <= 1'b1;
      ser_crd <= 1'b0;
    end else begin
      ser_crd <= 1'b0;
      if (!run || bdr_end) bdr_cnt <= '0;
      else                 bdr_cnt <= bdr_cnt + 1'b1;
      if (!run) begin
        // credit scheme keeps ser_vld away from a busy frame
        if (ser_vld) begin
          run     <= 1'b1;
          bit_cnt <= '0;
          txd     <= 1'b0;
        end
      end else if (bdr_end) begin
        if (bit_end) begin
          // last stop clock done, line idle, credit back
          run     <= 1'b0;
          txd     <= 1'b1;
          ser_crd <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          txd     <= shf[0];
        end
      end
    end
  end

  // shift register, ones fill behind the stop bit
  always_ff @(posedge clk) begin
    if (!run && ser_vld)    shf <= {1'b1, ser_dat};
    else if (run && bdr_end) shf <= {1'b1, shf[DW:1]};
  end

endmodule : uart_ser

`default_nettype wire

//--- design/uart_tx_buf.sv
////////////////////
// uart transmit buffer
// credit-flow FIFO between the host and the serializer
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_tx_buf import uart_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // host side, host counts credits
  input  logic  tx_vld,
  input  byte_t tx_dat,
  output logic  tx_crd,
  // serializer side
  output logic  ser_vld,
  output byte_t ser_dat,
  input  logic  ser_crd
);

  byte_t          mem [TX_DEPTH];
  // extra msb tells full from empty
  logic [TX_AW:0] wr_ptr;
  logic [TX_AW:0] rd_ptr;
  logic           empty;
  // single serializer credit
  logic           crd;
  logic           pop;

  assign empty = wr_ptr == rd_ptr;
  assign pop   = ~empty & crd;

  // host never writes without a free slot
  always_ff @(posedge clk) begin
    if (tx_vld) mem[wr_ptr[TX_AW-1:0]] <= tx_dat;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      crd     <= 1'b1;
      ser_vld <= 1'b0;
      tx_crd  <= 1'b0;
    end else begin
      if (tx_vld) wr_ptr <= wr_ptr + 1'b1;
      if (pop)    rd_ptr <= rd_ptr + 1'b1;
      // frame in flight until ser_crd
      if (pop)          crd <= 1'b0;
      else if (ser_crd) crd <= 1'b1;
      ser_vld <= pop;
      // slot freed, host credit one cycle later
      tx_crd  <= ser_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) ser_dat <= mem[rd_ptr[TX_AW-1:0]];
  end

endmodule : uart_tx_buf

`default_nettype wire

//--- design/uart_rx_buf.sv
////////////////////
// uart receive buffer
// byte FIFO with error bits, sticky overrun and
// a host credit counter on the output
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_rx_buf import uart_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // from the deserializer
  input  logic  des_vld,
  input  byte_t des_dat,
  input  logic  des_err,
  // host side, credits granted by the host
  input  logic  rx_crd,
  output logic  rx_vld,
  output byte_t rx_dat,
  output logic  rx_err,
  output logic  rx_ovr
);

  // error bit stored above the byte
  logic [DW:0]      mem [RX_DEPTH];
  logic [RX_AW:0]   wr_ptr;
  logic [RX_AW:0]   rd_ptr;
  logic             empty;
  logic             full;
  logic             wr;
  logic [CRD_W-1:0] crd_cnt;

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[RX_AW] != rd_ptr[RX_AW]) &&
                 (wr_ptr[RX_AW-1:0] == rd_ptr[RX_AW-1:0]);
  // a byte arriving at a full FIFO is lost
  assign wr    = des_vld & ~full;

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr[RX_AW-1:0]] <= {des_err, des_dat};
  end

  // head entry, only meaningful with rx_vld
  assign {rx_err, rx_dat} = mem[rd_ptr[RX_AW-1:0]];

  // one byte per cycle, data waiting and credit held
  assign rx_vld = ~empty & (crd_cnt != '0);

  ////////////////////
  // pointers, credits, overrun
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      crd_cnt <= '0;
      rx_ovr  <= 1'b0;
    end else begin
      if (wr)     wr_ptr <= wr_ptr + 1'b1;
      if (rx_vld) rd_ptr <= rd_ptr + 1'b1;
      // grant and send together cancel out
      case ({rx_crd, rx_vld})
        2'b10:   crd_cnt <= crd_cnt + 1'b1;
        2'b01:   crd_cnt <= crd_cnt - 1'b1;
        default: crd_cnt <= crd_cnt;
      endcase
      // sticky until reset
      if (des_vld && full) rx_ovr <= 1'b1;
    end
  end

endmodule : uart_rx_buf

`default_nettype wire

//--- design/uart_top.sv
////////////////////
// uart transceiver top
// tx path buffer to serializer, rx path
// deserializer to buffer
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  // bit timing
  input  logic [CW-1:0] cfg_bdr,
  input  logic [CW-1:0] cfg_smp,
  // host transmit, credit flow
  input  logic          tx_vld,
  input  byte_t         tx_dat,
  output logic          tx_crd,
  // host receive, credit flow
  input  logic          rx_crd,
  output logic          rx_vld,
  output byte_t         rx_dat,
  output logic          rx_err,
  output logic          rx_ovr,
  // serial lines
  output logic          txd,
  input  logic          rxd
);

  // buffer to serializer
  logic  ser_vld;
  byte_t ser_dat;
  logic  ser_crd;
  // deserializer to buffer
  logic  des_vld;
  byte_t des_dat;
  logic  des_err;

  ////////////////////
  // transmit path
  ////////////////////

  uart_tx_buf u_tx_buf (
    .clk     (clk),
    .rst     (rst),
    .tx_vld  (tx_vld),
    .tx_dat  (tx_dat),
    .tx_crd  (tx_crd),
    .ser_vld (ser_vld),
    .ser_dat (ser_dat),
    .ser_crd (ser_crd)
  );

  uart_ser u_ser (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .ser_vld (ser_vld),
    .ser_dat (ser_dat),
    .txd     (txd),
    .ser_crd (ser_crd)
  );

  ////////////////////
  // receive path
  ////////////////////

  uart_des u_des (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .rxd     (rxd),
    .des_vld (des_vld),
    .des_dat (des_dat),
    .des_err (des_err)
  );

  uart_rx_buf u_rx_buf (
    .clk     (clk),
    .rst     (rst),
    .des_vld (des_vld),
    .des_dat (des_dat),
    .des_err (des_err),
    .rx_crd  (rx_crd),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_err  (rx_err),
    .rx_ovr  (rx_ovr)
  );

endmodule : uart_top

`default_nettype wire

//--- tb/uart_tb.sv
////////////////////
// uart transceiver testbench
// directed credit-flow tests over loopback and
// a driven serial line
////////////////////

`default_nettype none
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

  // bit timing under test
  localparam int BDR       = 7;
  localparam int SMP       = 3;
  localparam int BIT_CYC   = BDR + 1;
  localparam int FRAME_CYC = SL * BIT_CYC;
  // about 40 frames plus margin
  localparam int LIMIT     = 6000;

  logic          clk;
  logic          rst;
  logic [CW-1:0] cfg_bdr;
  logic [CW-1:0] cfg_smp;
  logic          tx_vld;
  byte_t         tx_dat;
  logic          tx_crd;
  logic          rx_crd;
  logic          rx_vld;
  byte_t         rx_dat;
  logic          rx_err;
  logic          rx_ovr;
  logic          txd;
  logic          rxd;
  // rxd source is loopback or driven bit by bit
  logic          drive_mode;
  logic          drv_bit;

  // host model
  int            sent_cnt;
  int            crd_ret;
  logic [DW:0]   got_q [$];
  logic [DW:0]   exp_q [$];

  int            seed;
  int            cycles = 0;
  int            err_cnt;
  int            test_err0;
  int            pass_cnt;
  int            fail_cnt;

  uart_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .cfg_smp (cfg_smp),
    .tx_vld  (tx_vld),
    .tx_dat  (tx_dat),
    .tx_crd  (tx_crd),
    .rx_crd  (rx_crd),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_err  (rx_err),
    .rx_ovr  (rx_ovr),
    .txd     (txd),
    .rxd     (rxd)
  );

  assign rxd = drive_mode ? drv_bit : txd;

  // 4 ns period
  always #2 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run stopped after %0d cycles, tests did not finish", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // host side monitor
  ////////////////////

  // pre-edge values seen here, so a pop or credit counts at this edge
  always @(posedge clk) begin
    if (!rst) begin
      if (rx_vld) got_q.push_back({rx_err, rx_dat});
      if (tx_crd) crd_ret = crd_ret + 1;
    end
  end

  function automatic int host_crd();
    return int'(TX_DEPTH) - sent_cnt + crd_ret;
  endfunction

  ////////////////////
  // helpers
  ////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail t=%0t %s got %0h exp %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("error at t=%0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic start_test();
    test_err0 = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err0) begin
      pass_cnt++;
      $display("%s: passed", name);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", name, err_cnt - test_err0);
    end
  endtask

  // called and returns at a negedge
  task automatic send_byte(input byte_t d);
    int i;
    i = 0;
    while (host_crd() == 0 && i < 4 * FRAME_CYC) begin
      @(negedge clk);
      i++;
    end
    if (host_crd() == 0) begin
      report_error("no tx credit came back to the host");
    end else begin
      tx_vld   = 1'b1;
      tx_dat   = d;
      sent_cnt = sent_cnt + 1;
      @(negedge clk);
      tx_vld = 1'b0;
    end
  endtask

  // n back to back credit pulses
  task automatic grant_rx(input int n);
    rx_crd = 1'b1;
    repeat (n) @(negedge clk);
    rx_crd = 1'b0;
  endtask

  task automatic wait_rx(input int n, input int limit);
    int i;
    i = 0;
    while (got_q.size() < n && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (got_q.size() < n)
      report_error($sformatf("only %0d of %0d bytes reached the host", got_q.size(), n));
  endtask

  task automatic wait_host_full();
    int i;
    i = 0;
    while (host_crd() != TX_DEPTH && i < 4 * FRAME_CYC) begin
      @(negedge clk);
      i++;
    end
    if (host_crd() != TX_DEPTH) report_error("host tx credits never returned to full");
  endtask

  task automatic compare_rx(input int n);
    logic [DW:0] got;
    logic [DW:0] exp;
    for (int i = 0; i < n; i++) begin
      if (got_q.size() == 0 || exp_q.size() == 0) begin
        report_error("received byte missing for comparison");
      end else begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        if (got[DW-1:0] !== exp[DW-1:0])
          report_mismatch("rx_dat", 32'(got[DW-1:0]), 32'(exp[DW-1:0]));
        if (got[DW] !== exp[DW]) report_mismatch("rx_err", 32'(got[DW]), 32'(exp[DW]));
      end
    end
  endtask

  // start, data lsb first, given stop, then idle gap
  task automatic drive_frame(input byte_t d, input logic stop);
    drv_bit = 1'b0;
    repeat (BIT_CYC) @(negedge clk);
    for (int i = 0; i < DW; i++) begin
      drv_bit = d[i];
      repeat (BIT_CYC) @(negedge clk);
    end
    drv_bit = stop;
    repeat (BIT_CYC) @(negedge clk);
    drv_bit = 1'b1;
    repeat (2 * BIT_CYC) @(negedge clk);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset();
    start_test();
    if (txd !== 1'b1) report_mismatch("txd", 32'(txd), 1);
    if (rx_vld !== 1'b0) report_mismatch("rx_vld", 32'(rx_vld), 0);
    if (tx_crd !== 1'b0) report_mismatch("tx_crd", 32'(tx_crd), 0);
    if (rx_ovr !== 1'b0) report_mismatch("rx_ovr", 32'(rx_ovr), 0);
    finish_test("reset state");
  endtask

  task automatic test_single();
    int ret0;
    start_test();
    ret0 = crd_ret;
    grant_rx(1);
    exp_q.push_back({1'b0, 8'hA5});
    send_byte(8'hA5);
    wait_rx(1, 2 * FRAME_CYC);
    // let a second pop show up if there is one
    repeat (2 * BIT_CYC) @(negedge clk);
    if (got_q.size() != 1) report_mismatch("rx_vld pulses", 32'(got_q.size()), 1);
    if (crd_ret - ret0 != 1) report_mismatch("tx_crd pulses", 32'(crd_ret - ret0), 1);
    compare_rx(1);
    finish_test("single loopback");
  endtask

  task automatic test_burst();
    logic [31:0] rnd;
    start_test();
    wait_host_full();
    grant_rx(TX_DEPTH);
    for (int i = 0; i < TX_DEPTH; i++) begin
      rnd = $random(seed);
      exp_q.push_back({1'b0, rnd[DW-1:0]});
      send_byte(rnd[DW-1:0]);
    end
    wait_rx(TX_DEPTH, (TX_DEPTH + 1) * FRAME_CYC);
    compare_rx(TX_DEPTH);
    // last pop was a whole frame ago, every credit is back
    if (host_crd() != TX_DEPTH) report_mismatch("host credits", 32'(host_crd()), TX_DEPTH);
    finish_test("burst in order");
  endtask

  task automatic test_withhold();
    logic [31:0] rnd;
    start_test();
    wait_host_full();
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      exp_q.push_back({1'b0, rnd[DW-1:0]});
      send_byte(rnd[DW-1:0]);
    end
    // nothing may come out while three frames cross the line
    repeat (3 * FRAME_CYC + 40) @(negedge clk);
    if (got_q.size() != 0) report_error("byte presented to the host without an rx credit");
    grant_rx(3);
    wait_rx(3, 40);
    compare_rx(3);
    repeat (2 * BIT_CYC) @(negedge clk);
    if (got_q.size() != 0) report_error("byte presented after rx credits ran out");
    finish_test("credit withholding");
  endtask

  task automatic test_framing();
    start_test();
    wait_host_full();
    // serializer idle before the line is taken over
    repeat (FRAME_CYC) @(negedge clk);
    drive_mode = 1'b1;
    grant_rx(2);
    // stop bit low
    exp_q.push_back({1'b1, 8'h3C});
    drive_frame(8'h3C, 1'b0);
    exp_q.push_back({1'b0, 8'hC3});
    drive_frame(8'hC3, 1'b1);
    wait_rx(2, FRAME_CYC);
    compare_rx(2);
    drive_mode = 1'b0;
    finish_test("framing error");
  endtask

  task automatic test_overrun();
    logic [31:0] rnd;
    int          i;
    start_test();
    wait_host_full();
    // no FIFO has overflowed in the earlier tests
    if (rx_ovr !== 1'b0) report_mismatch("rx_ovr", 32'(rx_ovr), 0);
    for (int k = 0; k <= RX_DEPTH; k++) begin
      rnd = $random(seed);
      // last byte meets a full FIFO and is lost
      if (k < RX_DEPTH) exp_q.push_back({1'b0, rnd[DW-1:0]});
      send_byte(rnd[DW-1:0]);
    end
    i = 0;
    while (rx_ovr !== 1'b1 && i < (RX_DEPTH + 2) * FRAME_CYC) begin
      @(negedge clk);
      i++;
    end
    if (rx_ovr !== 1'b1) report_mismatch("rx_ovr", 32'(rx_ovr), 1);
    if (got_q.size() != 0) report_error("byte presented to the host without an rx credit");
    grant_rx(RX_DEPTH + 1);
    wait_rx(RX_DEPTH, 40);
    repeat (2 * BIT_CYC) @(negedge clk);
    if (got_q.size() != RX_DEPTH) report_mismatch("bytes after overrun", 32'(got_q.size()),
                                                  RX_DEPTH);
    compare_rx(RX_DEPTH);
    if (rx_ovr !== 1'b1) report_mismatch("rx_ovr", 32'(rx_ovr), 1);
    finish_test("overrun");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed       = 97879;
    clk        = 1'b0;
    rst        = 1'b1;
    cfg_bdr    = CW'(BDR);
    cfg_smp    = CW'(SMP);
    tx_vld     = 1'b0;
    tx_dat     = '0;
    rx_crd     = 1'b0;
    drive_mode = 1'b0;
    drv_bit    = 1'b1;
    sent_cnt   = 0;
    crd_ret    = 0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset();
    test_single();
    test_burst();
    test_withhold();
    test_framing();
    test_overrun();
    $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : uart_tb

`default_nettype wire

//--- all.f
design/uart_pkg.sv
design/uart_des.sv
design/uart_ser.sv
design/uart_tx_buf.sv
design/uart_rx_buf.sv
design/uart_top.sv
tb/uart_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the uart testbench with verilator, run it, check the result line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module uart_tb \
  -f all.f \
  -o uart_tb_sim

out=$(./obj_dir/uart_tb_sim)
echo "$out"

if grep -q "TEST RESULT: PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi
